// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
TOP       ?= tb_dram_ctrl
FILELIST  ?= build.f
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== build.f ====
hdl/dram_ctrl_pkg.sv
hdl/ctrl_opb_attach.sv
hdl/dram_arbiter.sv
hdl/dram_cmd_seq.sv
hdl/dram_ctrl_top.sv
testbench/tb_clk_gen.sv
testbench/tb_dram_ctrl.sv

// ==== hdl/ctrl_opb_attach.sv ====
`timescale 1ns/1ns

module ctrl_opb_attach #(
  parameter logic [31:0] c_baseaddr = 32'h0000_0000,
  parameter logic [31:0] c_highaddr = 32'h0000_0020
) (
  input  logic                       OPB_Clk,
  input  logic                       rst_n,
  input  dram_ctrl_pkg::opb_req_t    opb_in,
  output dram_ctrl_pkg::opb_resp_t   opb_out,

  output logic [15:0]                software_address_bits,
  output logic                       cpu_override_en,
  output logic                       cpu_override_sel,
  input  dram_ctrl_pkg::seq_state_e  mem_dram_state,
  input  dram_ctrl_pkg::port_state_e mem_opb_state,
  input  logic [7:0]                 max_clks,
  input  dram_ctrl_pkg::arb_state_e  arbiter_state,
  input  logic                       arbiter_conflict,
  input  logic                       phy_ready
);
  import dram_ctrl_pkg::*;

  logic [31:0] abus;
  logic [31:0] offset;
  logic        opb_sel;
  logic        chip_select;
  logic [2:0]  word_idx;
  logic        known_reg;
  logic        access;
  logic        xfer_ack_q;
  logic        err_ack_q;
  logic [0:31] rd_data;
  logic [0:31] dbus_q;
  logic [15:0] soft_addr_q;
  logic        ov_en_q;
  logic        ov_sel_q;

  assign abus    = opb_in.abus;   // same value, little-endian indexing
  assign offset  = abus - c_baseaddr;
  assign opb_sel = opb_in.select && (abus >= c_baseaddr) && (abus < c_highaddr);

  // second edge of a transfer, once per select
  assign access    = opb_sel && chip_select && !xfer_ack_q && !err_ack_q;
  assign known_reg = (word_idx <= reg_memstate);

  // word index captured on the first edge, address is held by the master
  always_ff @(posedge OPB_Clk) begin
    if (opb_sel) begin
      word_idx <= offset[4:2];
    end
  end

  always_comb begin
    case (word_idx)
      reg_softaddr: rd_data = {16'h0, soft_addr_q};
      reg_phyready: rd_data = {31'h0, phy_ready};
      reg_override: rd_data = {24'h0, ov_sel_q, 6'h0, ov_en_q};
      reg_arbstate: rd_data = {24'h0, arbiter_conflict, 3'h0, arbiter_state};
      reg_memstate: rd_data = {16'h0, max_clks, mem_opb_state, mem_dram_state};
      default:      rd_data = 32'h0;    // unmapped words read zero
    endcase
  end

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      chip_select <= 1'b0;
      xfer_ack_q  <= 1'b0;
      err_ack_q   <= 1'b0;
      dbus_q      <= 32'h0;
      soft_addr_q <= 16'h0;
      ov_en_q     <= 1'b0;
      ov_sel_q    <= 1'b0;
    end else begin
      xfer_ack_q  <= 1'b0;              // acks are single-cycle pulses
      err_ack_q   <= 1'b0;
      dbus_q      <= 32'h0;             // bus idles at zero
      chip_select <= opb_sel && !xfer_ack_q && !err_ack_q;
      if (access) begin
        xfer_ack_q <= known_reg;
        err_ack_q  <= !known_reg;
        if (opb_in.rnw) begin
          dbus_q <= rd_data;
        end else begin
          case (word_idx)
            reg_softaddr: begin
              if (opb_in.be[3]) begin
                soft_addr_q[7:0] <= opb_in.dbus[24:31];
              end
              if (opb_in.be[2]) begin
                soft_addr_q[15:8] <= opb_in.dbus[16:23];
              end
            end
            reg_override: begin
              if (opb_in.be[3]) begin
                ov_en_q  <= opb_in.dbus[31];
                ov_sel_q <= opb_in.dbus[24];
              end
            end
            default: begin
              // status words ignore writes
            end
          endcase
        end
      end
    end
  end

  assign opb_out.dbus     = dbus_q;
  assign opb_out.err_ack  = err_ack_q;
  assign opb_out.retry    = 1'b0;
  assign opb_out.tout_sup = 1'b0;
  assign opb_out.xfer_ack = xfer_ack_q;

  assign software_address_bits = soft_addr_q;
  assign cpu_override_en       = ov_en_q;
  assign cpu_override_sel      = ov_sel_q;    // 1 forces cpu, 0 forces user

endmodule

// ==== hdl/dram_arbiter.sv ====
`timescale 1ns/1ns

module dram_arbiter (
  input  logic                       OPB_Clk,
  input  logic                       rst_n,
  input  logic [15:0]                software_address_bits,
  input  logic                       cpu_override_en,
  input  logic                       cpu_override_sel,
  input  logic                       cpu_req,
  input  logic                       cpu_rnw,
  input  logic [15:0]                cpu_offset,
  input  logic                       user_req,
  input  logic                       user_rnw,
  input  logic [31:0]                user_addr,
  input  logic                       seq_ready,
  input  logic                       seq_done,
  output logic                       cpu_grant,
  output logic                       cpu_done,
  output logic                       user_grant,
  output logic                       user_done,
  output logic                       cmd_valid,
  output dram_ctrl_pkg::mem_cmd_t    cmd,
  output dram_ctrl_pkg::arb_state_e  arbiter_state,
  output logic                       arbiter_conflict,
  output dram_ctrl_pkg::port_state_e mem_opb_state,
  output logic [7:0]                 max_clks
);
  import dram_ctrl_pkg::*;

  localparam int port_user = 0;
  localparam int port_cpu  = 1;

  arb_state_e state;
  logic       owner_cpu;
  logic       prefer_cpu;
  logic [1:0] req_vec;
  logic [1:0] elig;
  logic [1:0] owns;
  logic       contested;
  logic       issue;
  logic       pick_cpu;
  logic [7:0] wait_cnt [2];
  logic [7:0] win_wait;

  function automatic logic [7:0] sat_inc(input logic [7:0] v);
    return (v == 8'hff) ? v : v + 8'd1;
  endfunction

  assign req_vec = {cpu_req, user_req};

  // override narrows eligibility to one port
  assign elig[port_cpu]  = cpu_req && (!cpu_override_en || cpu_override_sel);
  assign elig[port_user] = user_req && (!cpu_override_en || !cpu_override_sel);
  assign contested       = &elig;
  assign issue           = (state == arb_idle) && seq_ready && (|elig);
  assign pick_cpu        = contested ? prefer_cpu : elig[port_cpu];

  assign owns[port_cpu]  = (state != arb_idle) && owner_cpu;
  assign owns[port_user] = (state != arb_idle) && !owner_cpu;

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= arb_idle;
      owner_cpu  <= 1'b0;
      prefer_cpu <= 1'b0;                 // first contest goes to user
    end else begin
      case (state)
        arb_idle: begin
          if (issue) begin
            state     <= pick_cpu ? arb_grant_cpu : arb_grant_user;
            owner_cpu <= pick_cpu;
            if (contested) begin
              prefer_cpu <= !pick_cpu;      // alternate on contention only
            end
          end
        end
        arb_grant_user, arb_grant_cpu: state <= arb_busy;
        arb_busy: begin
          if (seq_done) begin
            state <= arb_idle;
          end
        end
        default: state <= arb_idle;
      endcase
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (issue) begin
      cmd.addr <= pick_cpu ? {software_address_bits, cpu_offset} : user_addr;
      cmd.rnw  <= pick_cpu ? cpu_rnw : user_rnw;
      cmd.src  <= pick_cpu;
    end
  end

  // wait counters per port, cleared once the port owns the sequencer
  assign win_wait = sat_inc(wait_cnt[pick_cpu]);

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt[port_user] <= 8'h0;
      wait_cnt[port_cpu]  <= 8'h0;
      max_clks            <= 8'h0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (!req_vec[p] || owns[p]) begin
          wait_cnt[p] <= 8'h0;
        end else begin
          wait_cnt[p] <= sat_inc(wait_cnt[p]);
        end
      end
      if (issue && (win_wait > max_clks)) begin
        max_clks <= win_wait;               // counts the grant cycle too
      end
    end
  end

  always_comb begin
    if (owns[port_cpu]) begin
      mem_opb_state = port_active;
    end else if (cpu_req) begin
      mem_opb_state = port_pending;
    end else begin
      mem_opb_state = port_idle;
    end
  end

  assign cpu_grant        = (state == arb_grant_cpu);
  assign user_grant       = (state == arb_grant_user);
  assign cmd_valid        = cpu_grant || user_grant;
  assign cpu_done         = seq_done && owns[port_cpu];
  assign user_done        = seq_done && owns[port_user];
  assign arbiter_state    = state;
  assign arbiter_conflict = &(req_vec & ~owns);   // both still waiting

endmodule

// ==== hdl/dram_cmd_seq.sv ====
`timescale 1ns/1ns

module dram_cmd_seq #(
  parameter int init_cycles = 20,
  parameter int t_rcd       = 3,
  parameter int t_rp        = 2
) (
  input  logic                      OPB_Clk,
  input  logic                      rst_n,
  input  logic                      cmd_valid,
  input  dram_ctrl_pkg::mem_cmd_t   cmd,
  output logic                      seq_ready,
  output logic                      seq_done,
  output logic                      phy_ready,
  output dram_ctrl_pkg::seq_state_e mem_dram_state
);
  import dram_ctrl_pkg::*;

  localparam int init_w  = $clog2(init_cycles + 1);
  localparam int phase_w = $clog2(((t_rcd > t_rp) ? t_rcd : t_rp) + 1);

  seq_state_e          state;
  logic [init_w-1:0]   init_cnt;
  logic [phase_w-1:0]  phase_cnt;

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= seq_init;
      init_cnt  <= '0;
      phase_cnt <= '0;
      phy_ready <= 1'b0;
      seq_done  <= 1'b0;
    end else begin
      seq_done <= 1'b0;
      case (state)
        seq_init: begin
          if (init_cnt == init_w'(init_cycles - 1)) begin
            state     <= seq_idle;
            phy_ready <= 1'b1;
          end else begin
            init_cnt <= init_cnt + 1'b1;
          end
        end
        seq_idle: begin
          if (cmd_valid) begin
            state     <= seq_act;
            phase_cnt <= phase_w'(t_rcd - 1);
          end
        end
        seq_act: begin
          if (phase_cnt == '0) begin
            state <= seq_rw;            // single column access cycle
          end else begin
            phase_cnt <= phase_cnt - 1'b1;
          end
        end
        seq_rw: begin
          state     <= seq_pre;
          phase_cnt <= phase_w'(t_rp - 1);
        end
        seq_pre: begin
          if (phase_cnt == '0) begin
            state    <= seq_idle;
            seq_done <= 1'b1;
          end else begin
            phase_cnt <= phase_cnt - 1'b1;
          end
        end
        default: state <= seq_idle;
      endcase
    end
  end

  // ready returns the cycle after done
  assign seq_ready      = (state == seq_idle) && !seq_done;
  assign mem_dram_state = state;

endmodule

// ==== hdl/dram_ctrl_pkg.sv ====
package dram_ctrl_pkg;

  // word indices of the OPB register map (byte offset bits 4:2)
  localparam logic [2:0] reg_softaddr = 3'd0;
  localparam logic [2:0] reg_phyready = 3'd1;
  localparam logic [2:0] reg_override = 3'd2;
  localparam logic [2:0] reg_arbstate = 3'd3;
  localparam logic [2:0] reg_memstate = 3'd4;

  // OPB master to slave, big-endian bit order (bit 31 is the lsb)
  typedef struct packed {
    logic [0:31] abus;
    logic [0:3]  be;       // be[3] covers dbus[24:31]
    logic [0:31] dbus;
    logic        rnw;
    logic        select;
    logic        seq_addr; // bursts not supported
  } opb_req_t;

  // OPB slave to master
  typedef struct packed {
    logic [0:31] dbus;
    logic        err_ack;
    logic        retry;
    logic        tout_sup;
    logic        xfer_ack;
  } opb_resp_t;

  // one DRAM command as issued by the arbiter
  typedef struct packed {
    logic [31:0] addr;
    logic        rnw;
    logic        src;      // 1 = cpu port
  } mem_cmd_t;

  typedef enum logic [3:0] {
    arb_idle       = 4'd0,
    arb_grant_user = 4'd1,
    arb_grant_cpu  = 4'd2,
    arb_busy       = 4'd3
  } arb_state_e;

  // cpu port view, reported through reg_memstate
  typedef enum logic [3:0] {
    port_idle    = 4'd0,
    port_pending = 4'd1,
    port_active  = 4'd2
  } port_state_e;

  typedef enum logic [3:0] {
    seq_init = 4'd0,
    seq_idle = 4'd1,
    seq_act  = 4'd2,
    seq_rw   = 4'd3,
    seq_pre  = 4'd4
  } seq_state_e;

endpackage

// ==== hdl/dram_ctrl_top.sv ====
`timescale 1ns/1ns

module dram_ctrl_top #(
  parameter logic [31:0] c_baseaddr  = 32'h0000_0000,
  parameter logic [31:0] c_highaddr  = 32'h0000_0020,
  parameter int          init_cycles = 20,
  parameter int          t_rcd       = 3,
  parameter int          t_rp        = 2
) (
  input  logic                     OPB_Clk,
  input  logic                     rst_n,
  input  dram_ctrl_pkg::opb_req_t  opb_in,
  output dram_ctrl_pkg::opb_resp_t opb_out,

  input  logic                     cpu_req,
  input  logic                     cpu_rnw,
  input  logic [15:0]              cpu_offset,
  output logic                     cpu_grant,
  output logic                     cpu_done,
  input  logic                     user_req,
  input  logic                     user_rnw,
  input  logic [31:0]              user_addr,
  output logic                     user_grant,
  output logic                     user_done,

  output logic                     dram_cmd_valid,
  output dram_ctrl_pkg::mem_cmd_t  dram_cmd
);
  import dram_ctrl_pkg::*;

  logic [15:0] software_address_bits;
  logic        cpu_override_en;
  logic        cpu_override_sel;
  arb_state_e  arbiter_state;
  logic        arbiter_conflict;
  port_state_e mem_opb_state;
  seq_state_e  mem_dram_state;
  logic [7:0]  max_clks;
  logic        phy_ready;
  logic        seq_ready;
  logic        seq_done;

  ctrl_opb_attach #(
    .c_baseaddr (c_baseaddr),
    .c_highaddr (c_highaddr)
  ) u_opb_attach (
    .OPB_Clk               (OPB_Clk),
    .rst_n                 (rst_n),
    .opb_in                (opb_in),
    .opb_out               (opb_out),
    .software_address_bits (software_address_bits),
    .cpu_override_en       (cpu_override_en),
    .cpu_override_sel      (cpu_override_sel),
    .mem_dram_state        (mem_dram_state),
    .mem_opb_state         (mem_opb_state),
    .max_clks              (max_clks),
    .arbiter_state         (arbiter_state),
    .arbiter_conflict      (arbiter_conflict),
    .phy_ready             (phy_ready)
  );

  dram_arbiter u_arbiter (
    .OPB_Clk               (OPB_Clk),
    .rst_n                 (rst_n),
    .software_address_bits (software_address_bits),
    .cpu_override_en       (cpu_override_en),
    .cpu_override_sel      (cpu_override_sel),
    .cpu_req               (cpu_req),
    .cpu_rnw               (cpu_rnw),
    .cpu_offset            (cpu_offset),
    .user_req              (user_req),
    .user_rnw              (user_rnw),
    .user_addr             (user_addr),
    .seq_ready             (seq_ready),
    .seq_done              (seq_done),
    .cpu_grant             (cpu_grant),
    .cpu_done              (cpu_done),
    .user_grant            (user_grant),
    .user_done             (user_done),
    .cmd_valid             (dram_cmd_valid),   // also drives the DRAM port
    .cmd                   (dram_cmd),
    .arbiter_state         (arbiter_state),
    .arbiter_conflict      (arbiter_conflict),
    .mem_opb_state         (mem_opb_state),
    .max_clks              (max_clks)
  );

  dram_cmd_seq #(
    .init_cycles (init_cycles),
    .t_rcd       (t_rcd),
    .t_rp        (t_rp)
  ) u_cmd_seq (
    .OPB_Clk        (OPB_Clk),
    .rst_n          (rst_n),
    .cmd_valid      (dram_cmd_valid),
    .cmd            (dram_cmd),
    .seq_ready      (seq_ready),
    .seq_done       (seq_done),
    .phy_ready      (phy_ready),
    .mem_dram_state (mem_dram_state)
  );

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int period       = 8,
  parameter int reset_cycles = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;                      // released off the edge
  end

endmodule

// ==== testbench/tb_dram_ctrl.sv ====
`timescale 1ns/1ns

module tb_dram_ctrl;
  import dram_ctrl_pkg::*;

  localparam logic [31:0] base = 32'h0000_0000;
  localparam int init_cycles = 40;        // long enough for reads before phy ready
  localparam int t_rcd = 3;
  localparam int t_rp = 2;
  localparam int seq_lat = t_rcd + 1 + t_rp;
  localparam int max_cycles = 3000;       // whole run is well under this

  logic clk;
  logic rst_n;
  opb_req_t opb_in;
  opb_resp_t opb_out;
  logic cpu_req, cpu_rnw, cpu_grant, cpu_done;
  logic [15:0] cpu_offset;
  logic user_req, user_rnw, user_grant, user_done;
  logic [31:0] user_addr;
  logic dram_cmd_valid;
  mem_cmd_t dram_cmd;

  int errors = 0;
  int assert_errors = 0;
  int cycles = 0;
  int rst_cycles = 0;
  int longest_wait = 0;
  logic ov_on = 1'b0;
  logic [15:0] soft_model = 16'h0;
  bit grant_order[$];                     // 1 = cpu

  tb_clk_gen #(.period(8), .reset_cycles(5)) u_clk (.clk(clk), .rst_n(rst_n));

  dram_ctrl_top #(
    .c_baseaddr (base),
    .c_highaddr (base + 32'h20),
    .init_cycles(init_cycles),
    .t_rcd      (t_rcd),
    .t_rp       (t_rp)
  ) UUT (
    .OPB_Clk(clk), .rst_n(rst_n), .opb_in(opb_in), .opb_out(opb_out),
    .cpu_req(cpu_req), .cpu_rnw(cpu_rnw), .cpu_offset(cpu_offset),
    .cpu_grant(cpu_grant), .cpu_done(cpu_done),
    .user_req(user_req), .user_rnw(user_rnw), .user_addr(user_addr),
    .user_grant(user_grant), .user_done(user_done),
    .dram_cmd_valid(dram_cmd_valid), .dram_cmd(dram_cmd)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (rst_n) rst_cycles <= rst_cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  a_no_retry: assert property (@(posedge clk) !opb_out.retry && !opb_out.tout_sup)
    else begin
      assert_errors++;
      $display("retry or tout_sup driven high at %0t", $time);
    end
  a_xfer_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    opb_out.xfer_ack |=> !opb_out.xfer_ack)
    else begin
      assert_errors++;
      $display("xfer_ack held longer than one cycle");
    end
  a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    opb_out.err_ack |=> !opb_out.err_ack)
    else begin
      assert_errors++;
      $display("err_ack held longer than one cycle");
    end
  // done rises seq_lat edges after the edge that samples cmd_valid
  a_done_lat: assert property (@(posedge clk) disable iff (!rst_n)
    dram_cmd_valid |-> ##(seq_lat + 1) (cpu_done || user_done))
    else begin
      assert_errors++;
      $display("done pulse missing after command at %0t", $time);
    end
  a_early_cmd: assert property (@(posedge clk) disable iff (!rst_n)
    dram_cmd_valid |-> (rst_cycles > init_cycles))
    else begin
      assert_errors++;
      $display("command issued before phy ready");
    end
  a_override: assert property (@(posedge clk) disable iff (!rst_n) ov_on |-> !user_grant)
    else begin
      assert_errors++;
      $display("user port granted under cpu override");
    end

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // status 0 xfer_ack, 1 err_ack, 2 no response within 10 cycles
  task automatic opb_access(input logic [2:0] idx, input logic [31:0] addr, input logic rnw,
                            input logic [3:0] be, input logic [31:0] wdata,
                            output logic [31:0] rdata, output int status);
    int n;
    n = 0;
    status = 2;
    rdata = 32'h0;
    opb_in.abus = addr + {27'h0, idx, 2'b00};
    opb_in.rnw = rnw;
    opb_in.be = be;
    opb_in.dbus = wdata;
    opb_in.select = 1'b1;
    while (status == 2 && n < 10) begin
      @(posedge clk);
      #1 n++;
      if (opb_out.xfer_ack) status = 0;
      else if (opb_out.err_ack) status = 1;
    end
    rdata = opb_out.dbus;
    if (status != 2 && n != 2) begin
      errors++;
      $display("acknowledge came %0d cycles after select instead of 2", n);
    end
    if (opb_out.xfer_ack && opb_out.err_ack) begin
      errors++;
      $display("xfer_ack and err_ack high together");
    end
    opb_in.select = 1'b0;
    @(posedge clk);
    #1;                                   // bus idle cycle between transfers
  endtask

  task automatic reg_read(input logic [2:0] idx, output logic [31:0] rdata);
    int st;
    opb_access(idx, base, 1'b1, 4'hf, 32'h0, rdata, st);
    if (st != 0) begin
      errors++;
      $display("read of register %0d was not acknowledged", idx);
    end
  endtask

  task automatic reg_write(input logic [2:0] idx, input logic [3:0] be,
                           input logic [31:0] wdata);
    logic [31:0] d;
    int st;
    opb_access(idx, base, 1'b0, be, wdata, d, st);
    if (st != 0) begin
      errors++;
      $display("write of register %0d was not acknowledged", idx);
    end
  endtask

  task automatic wait_done(input bit is_cpu);
    int k;
    k = 0;
    while (!(is_cpu ? cpu_done : user_done) && k < 50) begin
      @(posedge clk);
      #1 k++;
    end
    if (k != seq_lat + 1) begin
      errors++;
      $display("done came %0d cycles after grant, expected %0d", k, seq_lat + 1);
    end
  endtask

  task automatic cpu_request(input logic [15:0] off, input logic rnw);
    int n;
    n = 0;
    cpu_offset = off;
    cpu_rnw = rnw;
    cpu_req = 1'b1;
    while (!cpu_grant && n < 300) begin
      @(posedge clk);
      #1 n++;
    end
    cpu_req = 1'b0;
    if (!cpu_grant) begin
      errors++;
      $display("cpu request was never granted");
    end else begin
      grant_order.push_back(1'b1);
      if (n > longest_wait) longest_wait = n;
      check_val("dram_cmd.addr", dram_cmd.addr, {soft_model, off});
      check_val("dram_cmd.src", {31'h0, dram_cmd.src}, 32'h1);
      check_val("dram_cmd.rnw", {31'h0, dram_cmd.rnw}, {31'h0, rnw});
      wait_done(1'b1);
    end
  endtask

  task automatic user_request(input logic [31:0] addr, input logic rnw);
    int n;
    n = 0;
    user_addr = addr;
    user_rnw = rnw;
    user_req = 1'b1;
    while (!user_grant && n < 300) begin
      @(posedge clk);
      #1 n++;
    end
    user_req = 1'b0;
    if (!user_grant) begin
      errors++;
      $display("user request was never granted");
    end else begin
      grant_order.push_back(1'b0);
      if (n > longest_wait) longest_wait = n;
      check_val("dram_cmd.addr", dram_cmd.addr, addr);
      check_val("dram_cmd.src", {31'h0, dram_cmd.src}, 32'h0);
      check_val("dram_cmd.rnw", {31'h0, dram_cmd.rnw}, {31'h0, rnw});
      wait_done(1'b0);
    end
  endtask

  task automatic check_order(input bit first);
    if (grant_order.size() != 2) begin
      errors++;
      $display("expected two grants in contest, saw %0d", grant_order.size());
    end else begin
      check_val("first_grant_cpu", {31'h0, grant_order[0]}, {31'h0, first});
      check_val("second_grant_cpu", {31'h0, grant_order[1]}, {31'h0, !first});
    end
    grant_order.delete();
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] wd;
    logic [3:0] be;
    int st;
    void'($urandom(17));
    opb_in = '0;
    cpu_req = 1'b0;
    cpu_rnw = 1'b0;
    cpu_offset = 16'h0;
    user_req = 1'b0;
    user_rnw = 1'b0;
    user_addr = 32'h0;
    @(posedge rst_n);
    @(posedge clk);
    #1;
    check_val("xfer_ack", {31'h0, opb_out.xfer_ack}, 32'h0);
    check_val("err_ack", {31'h0, opb_out.err_ack}, 32'h0);
    reg_read(reg_softaddr, rd);
    check_val("softaddr", rd, 32'h0);
    reg_read(reg_override, rd);
    check_val("override", rd, 32'h0);
    reg_read(reg_arbstate, rd);
    check_val("arbstate", rd, 32'h0);
    reg_read(reg_memstate, rd);
    check_val("memstate", rd, 32'h0);
    reg_read(reg_phyready, rd);
    check_val("phyready", rd, 32'h0);

    // both ports wait on the sequencer while the phy initializes
    fork
      cpu_request(16'h1234, 1'b1);
      user_request(32'hA000_0040, 1'b0);
      begin
        reg_read(reg_arbstate, rd);
        check_val("arbstate", rd, 32'h80);
        reg_read(reg_memstate, rd);
        check_val("memstate.port", {28'h0, rd[7:4]}, 32'h1);
      end
    join
    check_order(1'b0);
    reg_read(reg_phyready, rd);
    check_val("phyready", rd, 32'h1);

    fork
      cpu_request(16'h0008, 1'b0);
      user_request(32'h0000_1000, 1'b1);
    join
    check_order(1'b1);

    for (int i = 0; i < 8; i++) begin
      wd = $urandom();
      be = 4'($urandom());
      reg_write(reg_softaddr, be, wd);
      if (be[0]) soft_model[7:0] = wd[7:0];     // lane 3 is the low byte
      if (be[1]) soft_model[15:8] = wd[15:8];
      reg_read(reg_softaddr, rd);
      check_val("softaddr", rd, {16'h0, soft_model});
    end
    cpu_request(16'($urandom()), 1'b1);

    reg_write(reg_override, 4'h1, 32'h81);
    reg_read(reg_override, rd);
    check_val("override", rd, 32'h81);
    ov_on = 1'b1;
    fork
      user_request(32'h0BAD_0000, 1'b0);
      begin
        cpu_request(16'h00F0, 1'b1);
        cpu_request(16'h00F4, 1'b0);
        ov_on = 1'b0;
        reg_write(reg_override, 4'h1, 32'h0);
      end
    join
    grant_order.delete();
    reg_read(reg_memstate, rd);
    if ({24'h0, rd[15:8]} < longest_wait) begin
      errors++;
      $display("ERROR %0t max_clks got %0d expected at least %0d",
               $time, rd[15:8], longest_wait);
    end

    opb_access(3'd5, base, 1'b1, 4'hf, 32'h0, rd, st);
    check_val("index5_status", st, 32'h1);
    check_val("index5_data", rd, 32'h0);
    opb_access(3'd7, base, 1'b0, 4'hf, 32'hFFFF_FFFF, rd, st);
    check_val("index7_status", st, 32'h1);
    opb_access(3'd0, base + 32'h100, 1'b1, 4'hf, 32'h0, rd, st);
    check_val("out_of_range_status", st, 32'h2);

    $display("errors: %0d checks, %0d assertions", errors, assert_errors);
    if (errors == 0 && assert_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
